/* common/cart_pkg.sv */
// Shared constants and types for the cartridge side of the console core.
// Every cartridge module imports this package. Ports use scoped names.

`default_nettype none

package cart_pkg;

	// ------------------------------------------------------------
	// bus and memory widths
	// ------------------------------------------------------------
	localparam int CART_ADDR_W = 16;   // cpu cartridge address
	localparam int CART_DATA_W = 8;    // cpu data byte
	localparam int MEM_DATA_W  = 16;   // memory word, two byte lanes
	localparam int MEM_ADDR_W  = 21;   // word address, 4 MB of image space
	localparam int DL_ADDR_W   = 25;   // host download byte address

	// bank word layout
	localparam int BANK_W     = 9;
	localparam int ROM_BANK_W = 7;     // up to 128 banks of 16k
	localparam int RAM_BANK_W = 2;     // up to 4 banks of 8k

	// header bytes inside the image
	localparam logic [DL_ADDR_W-1:0] HDR_TYPE_ADDR = 25'h146;   // type in the high byte
	localparam logic [DL_ADDR_W-1:0] HDR_SIZE_ADDR = 25'h148;   // rom size low, ram size high

	// ------------------------------------------------------------
	// regions, cpu address bits 15..13
	// ------------------------------------------------------------
	localparam logic [2:0] REG_RAM_EN   = 3'd0;   // 0000-1FFF
	localparam logic [2:0] REG_ROM_BANK = 3'd1;   // 2000-3FFF
	localparam logic [2:0] REG_RAM_BANK = 3'd2;   // 4000-5FFF
	localparam logic [2:0] REG_MODE     = 3'd3;   // 6000-7FFF
	localparam logic [2:0] REGION_RAM   = 3'd5;   // A000-BFFF external ram

	localparam logic [3:0] RAM_EN_KEY = 4'hA;     // magic nibble that opens the ram
	localparam logic [7:0] OPEN_BUS   = 8'hFF;    // idle cartridge data lines

	// bank word, seen either as a rom bank or as a ram bank
	typedef union packed {
		struct packed {
			logic                  is_ram;      // selects the ram half of memory
			logic [ROM_BANK_W-1:0] rom_bank;
			logic                  half;        // 8k half of the 16k bank
		} rom;
		struct packed {
			logic                             is_ram;
			logic [BANK_W-RAM_BANK_W-2:0]     pad;
			logic [RAM_BANK_W-1:0]            ram_bank;
		} ram;
	} mem_bank_u;

	typedef enum logic [2:0] {
		NONE,
		MBC1,
		MBC2,
		MBC3,
		MBC5
	} mbc_kind_e;

	// mapper family from the header type byte, unlisted types run unmapped
	function automatic mbc_kind_e mbc_kind_decode(input logic [7:0] mbc_type);
		mbc_kind_e kind;
		case (mbc_type) inside
			[8'd1:8'd3]:   kind = MBC1;
			[8'd5:8'd6]:   kind = MBC2;
			[8'd15:8'd19]: kind = MBC3;   // clock variants included
			[8'd25:8'd30]: kind = MBC5;
			default:       kind = NONE;
		endcase
		return kind;
	endfunction

endpackage

`default_nettype wire

/* mbc/mbc_map.sv */
// Mapping half of the MBC. Turns the CPU address into a memory word
// address, forms the memory request and shapes the read byte.
// Request path is combinational, read shaping lines up with mem_rdata.

`timescale 1ns/1ps
`default_nettype none

module mbc_map (
	input  wire                                  clk_sys,
	input  wire                                  reset,
	input  wire  cart_pkg::mbc_kind_e            kind,
	input  wire  [7:0]                           hdr_rom_size,
	input  wire  [7:0]                           hdr_ram_size,
	input  wire                                  cart_ready,
	input  wire  [cart_pkg::ROM_BANK_W-1:0]      rom_bank_reg,
	input  wire  [cart_pkg::RAM_BANK_W-1:0]      ram_bank_reg,
	input  wire                                  mbc1_mode,
	input  wire                                  mbc3_clk_mode,
	input  wire                                  ram_enable,
	input  wire  [cart_pkg::CART_ADDR_W-1:0]     cart_addr,
	input  wire                                  cart_rd,
	input  wire                                  cart_wr,
	input  wire  [cart_pkg::CART_DATA_W-1:0]     cart_di,
	input  wire  [cart_pkg::MEM_DATA_W-1:0]      mem_rdata,
	output logic [cart_pkg::MEM_ADDR_W-1:0]      mem_addr,
	output logic [cart_pkg::MEM_DATA_W/8-1:0]    mem_be,
	output logic                                 mem_we,
	output logic                                 mem_re,
	output logic [cart_pkg::MEM_DATA_W-1:0]      mem_wdata,
	output logic [cart_pkg::CART_DATA_W-1:0]     cart_do
);
	import cart_pkg::*;

	logic [2:0]            region;
	logic [ROM_BANK_W-1:0] rom_mask;      // mirrors banks beyond the rom size
	logic [RAM_BANK_W-1:0] ram_mask;
	logic [ROM_BANK_W-1:0] rom_bank_sel;
	logic                  mbc2_ram;      // 512 x 4 bit ram inside the MBC2
	mem_bank_u             bank;
	logic                  rd_ready, rd_open, rd_nibble, rd_hi;
	logic [7:0]            rd_byte;

	assign region   = cart_addr[15:13];
	assign mbc2_ram = (kind == MBC2) && (cart_addr[15:9] == 7'b1010000);
	assign ram_mask = (hdr_ram_size > 8'd2) ? '1 : '0;   // 32k gives four banks

	// ------------------------------------------------------------
	// rom size to bank mask
	// ------------------------------------------------------------
	always_comb begin
		case (hdr_rom_size)
			8'h00:   rom_mask = 7'h01;   // 32k, two banks
			8'h01:   rom_mask = 7'h03;
			8'h02:   rom_mask = 7'h07;
			8'h03:   rom_mask = 7'h0F;
			8'h04:   rom_mask = 7'h1F;
			8'h05:   rom_mask = 7'h3F;
			8'h06:   rom_mask = 7'h7F;   // 2M
			8'h52:   rom_mask = 7'h47;   // 72 banks
			8'h53:   rom_mask = 7'h4F;   // 80 banks
			default: rom_mask = 7'h5F;
		endcase
	end

	// MBC1 mode 0 borrows the ram bank bits as rom bits 6..5
	always_comb begin
		if (kind == MBC1)
			rom_bank_sel = {mbc1_mode ? 2'b00 : ram_bank_reg, rom_bank_reg[4:0]};
		else
			rom_bank_sel = rom_bank_reg;
	end

	// ------------------------------------------------------------
	// bank word
	// ------------------------------------------------------------
	always_comb begin
		bank = '0;                                        // unmapped space hits word 0
		if (kind == NONE) begin
			bank.rom.rom_bank = {{(ROM_BANK_W-1){1'b0}}, cart_addr[14]};   // flat 32k
			bank.rom.half     = cart_addr[13];
		end else if (cart_addr[15:14] == 2'b00) begin
			bank.rom.half = cart_addr[13];                // fixed bank 0
		end else if (cart_addr[15:14] == 2'b01) begin
			bank.rom.rom_bank = rom_bank_sel & rom_mask;
			bank.rom.half     = cart_addr[13];
		end else if (region == REGION_RAM) begin
			case (kind)
				MBC1: begin
					bank.ram.is_ram   = 1'b1;
					bank.ram.ram_bank = mbc1_mode ? (ram_bank_reg & ram_mask) : '0;
				end
				MBC2: bank.ram.is_ram = mbc2_ram;        // A000-A1FF only
				MBC3: begin
					bank.ram.is_ram   = ~mbc3_clk_mode;  // clock mode unmaps ram
					bank.ram.ram_bank = mbc3_clk_mode ? '0 : (ram_bank_reg & ram_mask);
				end
				default: begin                          // MBC5
					bank.ram.is_ram   = 1'b1;
					bank.ram.ram_bank = ram_bank_reg & ram_mask;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// memory request
	// ------------------------------------------------------------
	assign mem_addr  = {bank, cart_addr[12:1]};
	assign mem_re    = cart_rd;
	assign mem_we    = cart_wr & ram_enable & (region == REGION_RAM);
	assign mem_be    = {cart_addr[0], ~cart_addr[0]};   // odd byte is the high lane
	assign mem_wdata = {cart_di, cart_di};

	// read decision, taken with the request and used with the data
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_ready  <= 1'b0;
			rd_open   <= 1'b0;
			rd_nibble <= 1'b0;
			rd_hi     <= 1'b0;
		end else if (cart_rd) begin
			rd_ready  <= cart_ready;
			rd_open   <= (region == REGION_RAM) & ~ram_enable;
			rd_nibble <= mbc2_ram;
			rd_hi     <= cart_addr[0];
		end
	end

	assign rd_byte = rd_hi ? mem_rdata[15:8] : mem_rdata[7:0];

	always_comb begin
		if (!rd_ready)
			cart_do = 8'h00;                     // nothing loaded yet
		else if (rd_open)
			cart_do = OPEN_BUS;                  // closed ram reads float high
		else if (rd_nibble)
			cart_do = {4'hF, rd_byte[3:0]};
		else
			cart_do = rd_byte;
	end

	// banked ram writes on MBC1 and MBC5 must land above the rom image
	a_we_in_ram: assert property (@(posedge clk_sys) disable iff (reset)
		mem_we && (kind == MBC1 || kind == MBC5) |-> mem_addr[MEM_ADDR_W-1])
		else $error("cartridge ram write lands in the rom image");

endmodule

`default_nettype wire

/* mbc/mbc_regs.sv */
// Mapper control registers written by the CPU into the ROM space.
// Region decode on A15..A13, new values act on the cycle after cart_wr.
// Reset and a running download both return the power-on values.

`timescale 1ns/1ps
`default_nettype none

module mbc_regs (
	input  wire                                  clk_sys,
	input  wire                                  reset,
	input  wire                                  dl_active,
	input  wire  cart_pkg::mbc_kind_e            kind,
	input  wire  [cart_pkg::CART_ADDR_W-1:0]     cart_addr,
	input  wire                                  cart_wr,
	input  wire  [cart_pkg::CART_DATA_W-1:0]     cart_di,
	output logic [cart_pkg::ROM_BANK_W-1:0]      rom_bank_reg,
	output logic [cart_pkg::RAM_BANK_W-1:0]      ram_bank_reg,
	output logic                                 mbc1_mode,
	output logic                                 mbc3_clk_mode,
	output logic                                 ram_enable
);
	import cart_pkg::*;

	logic [2:0] region;       // register select
	logic       rom_zero;     // bank write would select bank 0

	assign region   = cart_addr[15:13];
	assign rom_zero = (cart_di[4:0] == 5'd0) && (kind != MBC5);   // only MBC5 maps bank 0 high

	// ------------------------------------------------------------
	// register file
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			rom_bank_reg  <= ROM_BANK_W'(1);   // bank 1 at 4000 after power up
			ram_bank_reg  <= '0;
			mbc1_mode     <= 1'b0;
			mbc3_clk_mode <= 1'b0;
			ram_enable    <= 1'b0;             // ram closed until the key arrives
		end else if (cart_wr) begin
			case (region)
				REG_RAM_EN: begin
					ram_enable <= (cart_di[3:0] == RAM_EN_KEY);   // any other nibble closes
				end
				REG_ROM_BANK: begin
					if (rom_zero)
						rom_bank_reg <= ROM_BANK_W'(1);
					else
						rom_bank_reg <= cart_di[ROM_BANK_W-1:0];
				end
				REG_RAM_BANK: begin
					// MBC3 bit 3 points the window at the clock registers
					if (kind == MBC3 && cart_di[3]) begin
						mbc3_clk_mode <= 1'b1;
					end else begin
						mbc3_clk_mode <= 1'b0;
						ram_bank_reg  <= cart_di[RAM_BANK_W-1:0];
					end
				end
				REG_MODE: begin
					if (kind == MBC1)
						mbc1_mode <= cart_di[0];   // 0 rom banking, 1 ram banking
				end
				default: begin
					// writes above 7FFF never reach a register
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	// bank 0 at 4000 is only legal on MBC5, whatever the header said
	a_rom_bank_nonzero: assert property (@(posedge clk_sys) disable iff (reset)
		(kind == MBC5) || (rom_bank_reg != '0))
		else $error("rom bank register is zero on a non-MBC5 cartridge");

endmodule

`default_nettype wire

/* source/cart_loader.sv */
// Host download side. Takes one image word per dl_wr, holds the host off
// with dl_wait until the word is in memory, and grabs the header fields.

`timescale 1ns/1ps
`default_nettype none

module cart_loader (
	input  wire                                clk_sys,
	input  wire                                reset,
	input  wire                                dl_active,
	input  wire                                dl_wr,
	input  wire  [cart_pkg::DL_ADDR_W-1:0]     dl_addr,
	input  wire  [cart_pkg::MEM_DATA_W-1:0]    dl_data,
	output logic                               dl_wait,
	output logic                               ld_we,
	output logic [cart_pkg::MEM_ADDR_W-1:0]    ld_addr,
	output logic [cart_pkg::MEM_DATA_W-1:0]    ld_data,
	output logic [7:0]                         hdr_type,
	output logic [7:0]                         hdr_rom_size,
	output logic [7:0]                         hdr_ram_size,
	output logic                               cart_ready
);
	import cart_pkg::*;

	logic dl_take;   // accepted download word

	assign dl_take = dl_wr & dl_active;

	// ------------------------------------------------------------
	// handshake: wr -> wait -> write -> release
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_wait    <= 1'b0;
			ld_we      <= 1'b0;
			cart_ready <= 1'b0;
		end else begin
			if (dl_take)
				dl_wait <= 1'b1;              // host must hold off
			ld_we <= dl_wait & ~ld_we;        // one write per wait period
			if (ld_we) begin
				dl_wait    <= 1'b0;           // word committed, host may go on
				ld_we      <= 1'b0;
				cart_ready <= 1'b1;           // something valid in memory now
			end
		end
	end

	// word latch, byte address to word address
	always_ff @(posedge clk_sys) begin
		if (dl_take) begin
			ld_addr <= dl_addr[MEM_ADDR_W:1];
			ld_data <= dl_data;               // low byte is the even address
		end
	end

	// ------------------------------------------------------------
	// header capture, kept across downloads until reset
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hdr_type     <= 8'h00;
			hdr_rom_size <= 8'h00;
			hdr_ram_size <= 8'h00;
		end else if (dl_take) begin
			if (dl_addr == HDR_TYPE_ADDR)
				hdr_type <= dl_data[15:8];    // type is the odd byte 0x147
			if (dl_addr == HDR_SIZE_ADDR) begin
				hdr_rom_size <= dl_data[7:0];
				hdr_ram_size <= dl_data[15:8];
			end
		end
	end

	// the host must respect the wait window
	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wr |-> !dl_wait)
		else $error("download write while dl_wait is high");

endmodule

`default_nettype wire

/* source/cart_mem.sv */
// Cartridge image memory standing in for the external SDRAM.
// One port, per-lane byte writes, data out one cycle after re.

`timescale 1ns/1ps
`default_nettype none

module cart_mem #(
	parameter int ADDR_W = cart_pkg::MEM_ADDR_W
) (
	input  wire                                  clk_sys,
	input  wire                                  we,
	input  wire  [cart_pkg::MEM_DATA_W/8-1:0]    be,
	input  wire  [ADDR_W-1:0]                    addr,
	input  wire  [cart_pkg::MEM_DATA_W-1:0]      wdata,
	input  wire                                  re,
	output logic [cart_pkg::MEM_DATA_W-1:0]      rdata
);
	import cart_pkg::*;

	localparam int LANES = MEM_DATA_W / 8;
	localparam int DEPTH = 1 << ADDR_W;

	// rom image in the low half, cartridge ram above it
	logic [MEM_DATA_W-1:0] mem [0:DEPTH-1];

	// ------------------------------------------------------------
	// write side, lane 0 is the even byte
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (we) begin
			for (int i = 0; i < LANES; i++) begin
				if (be[i])
					mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
			end
		end
	end

	// ------------------------------------------------------------
	// read side, holds the last word between reads
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (re)
			rdata <= mem[addr];   // old data on a same-cycle write
	end

endmodule

`default_nettype wire

/* source/cart_top.sv */
// Cartridge top level. The loader fills memory during a download, then the
// mapper serves the CPU cartridge bus from the same memory port.

`timescale 1ns/1ps
`default_nettype none

module cart_top (
	input  wire                                  clk_sys,
	input  wire                                  reset,
	// host download
	input  wire                                  dl_active,
	input  wire                                  dl_wr,
	input  wire  [cart_pkg::DL_ADDR_W-1:0]       dl_addr,
	input  wire  [cart_pkg::MEM_DATA_W-1:0]      dl_data,
	output logic                                 dl_wait,
	// cpu cartridge bus
	input  wire  [cart_pkg::CART_ADDR_W-1:0]     cart_addr,
	input  wire                                  cart_rd,
	input  wire                                  cart_wr,
	input  wire  [cart_pkg::CART_DATA_W-1:0]     cart_di,
	output logic [cart_pkg::CART_DATA_W-1:0]     cart_do
);
	import cart_pkg::*;

	logic                    ld_we, map_we, map_re, cart_ready;
	logic [MEM_ADDR_W-1:0]   ld_addr, map_addr;
	logic [MEM_DATA_W-1:0]   ld_data, map_wdata, mem_rdata;
	logic [MEM_DATA_W/8-1:0] map_be;
	logic [7:0]              hdr_type, hdr_rom_size, hdr_ram_size;
	mbc_kind_e               kind;
	logic [ROM_BANK_W-1:0]   rom_bank_reg;
	logic [RAM_BANK_W-1:0]   ram_bank_reg;
	logic                    mbc1_mode, mbc3_clk_mode, ram_enable;

	assign kind = mbc_kind_decode(hdr_type);   // one decode for both mapper halves

	cart_loader cart_loader_i (
		.clk_sys, .reset, .dl_active, .dl_wr, .dl_addr, .dl_data, .dl_wait,
		.ld_we, .ld_addr, .ld_data, .hdr_type, .hdr_rom_size, .hdr_ram_size, .cart_ready
	);

	// ------------------------------------------------------------
	// memory port, loader owns it during a download
	// ------------------------------------------------------------
	cart_mem #(.ADDR_W(MEM_ADDR_W)) cart_mem_i (
		.clk_sys,
		.we    (dl_active ? ld_we : map_we),
		.be    (dl_active ? 2'b11 : map_be),       // whole words from the host
		.addr  (dl_active ? ld_addr : map_addr),
		.wdata (dl_active ? ld_data : map_wdata),
		.re    (map_re & ~dl_active),
		.rdata (mem_rdata)
	);

	mbc_regs mbc_regs_i (
		.clk_sys, .reset, .dl_active, .kind, .cart_addr, .cart_wr, .cart_di,
		.rom_bank_reg, .ram_bank_reg, .mbc1_mode, .mbc3_clk_mode, .ram_enable
	);

	mbc_map mbc_map_i (
		.clk_sys, .reset, .kind, .hdr_rom_size, .hdr_ram_size, .cart_ready,
		.rom_bank_reg, .ram_bank_reg, .mbc1_mode, .mbc3_clk_mode, .ram_enable,
		.cart_addr, .cart_rd, .cart_wr, .cart_di, .mem_rdata,
		.mem_addr (map_addr), .mem_be (map_be), .mem_we (map_we),
		.mem_re (map_re), .mem_wdata (map_wdata), .cart_do
	);

endmodule

`default_nettype wire

/* src.f */
+incdir+test
common/cart_pkg.sv
source/cart_loader.sv
source/cart_mem.sv
mbc/mbc_regs.sv
mbc/mbc_map.sv
source/cart_top.sv
test/cart_tb.sv

/* test/cart_tb_table.svh */
// Step table for the cartridge testbench, included inside the testbench module.
// Columns: name, header type, rom size, ram size, op, cpu address, data, expected
// (expected is a byte for OP_RD, the image byte address of the base for OP_RDIMG)

localparam int OP_DL    = 0;   // download the image with this header
localparam int OP_WR    = 1;   // cpu write
localparam int OP_RD    = 2;   // cpu read, fixed expected byte
localparam int OP_RDIMG = 3;   // cpu read at a random offset, image byte expected
localparam int MAX_ENTRIES = 64;

logic [8*16-1:0] t_name [0:MAX_ENTRIES-1];
logic [7:0]      t_type [0:MAX_ENTRIES-1];
logic [7:0]      t_rom  [0:MAX_ENTRIES-1];
logic [7:0]      t_ram  [0:MAX_ENTRIES-1];
int              t_op   [0:MAX_ENTRIES-1];
logic [15:0]     t_addr [0:MAX_ENTRIES-1];
logic [7:0]      t_data [0:MAX_ENTRIES-1];
logic [23:0]     t_exp  [0:MAX_ENTRIES-1];
int              n_entries = 0;

task automatic add_entry(input logic [8*16-1:0] name, input logic [7:0] mtype,
		input logic [7:0] rom, input logic [7:0] ram, input int op,
		input logic [15:0] addr, input logic [7:0] data, input logic [23:0] exp);
	t_name[n_entries] = name;
	t_type[n_entries] = mtype;
	t_rom[n_entries]  = rom;
	t_ram[n_entries]  = ram;
	t_op[n_entries]   = op;
	t_addr[n_entries] = addr;
	t_data[n_entries] = data;
	t_exp[n_entries]  = exp;
	n_entries++;
endtask

task automatic load_table;
	add_entry("pre_dl_rd0", 0, 0, 0, OP_RD, 'h0000, 0, 'h00);   // not ready yet
	add_entry("pre_dl_rd4", 0, 0, 0, OP_RD, 'h4000, 0, 'h00);
	add_entry("none_dl", 'h00, 'h00, 'h00, OP_DL, 0, 0, 0);
	add_entry("none_lin0", 0, 0, 0, OP_RDIMG, 'h0000, 0, 'h00000);
	add_entry("none_lin2", 0, 0, 0, OP_RDIMG, 'h2000, 0, 'h02000);
	add_entry("none_lin4", 0, 0, 0, OP_RDIMG, 'h4000, 0, 'h04000);
	add_entry("none_lin6", 0, 0, 0, OP_RDIMG, 'h6000, 0, 'h06000);
	// MBC1, 1M rom so the bank mask is 0x3F, 32k ram
	add_entry("mbc1_dl", 'h03, 'h05, 'h03, OP_DL, 0, 0, 0);
	add_entry("mbc1_reset_bank", 0, 0, 0, OP_RDIMG, 'h4000, 0, 'h04000);
	add_entry("mbc1_bank5", 0, 0, 0, OP_WR, 'h2000, 'h05, 0);
	add_entry("mbc1_bank5_rd", 0, 0, 0, OP_RDIMG, 'h6000, 0, 'h16000);
	add_entry("mbc1_zero", 0, 0, 0, OP_WR, 'h2000, 'h00, 0);
	add_entry("mbc1_zero_rd", 0, 0, 0, OP_RDIMG, 'h4000, 0, 'h04000);   // 0 reads as 1
	add_entry("mbc1_bank1f", 0, 0, 0, OP_WR, 'h2000, 'h1F, 0);
	add_entry("mbc1_hi2", 0, 0, 0, OP_WR, 'h4000, 'h02, 0);
	add_entry("mbc1_mirror_rd", 0, 0, 0, OP_RDIMG, 'h4000, 0, 'h7C000);  // 0x5F -> 0x1F
	add_entry("mbc1_hi1", 0, 0, 0, OP_WR, 'h4000, 'h01, 0);
	add_entry("mbc1_hi1_rd", 0, 0, 0, OP_RDIMG, 'h4000, 0, 'hFC000);    // bank 0x3F
	add_entry("mbc1_mode1", 0, 0, 0, OP_WR, 'h6000, 'h01, 0);
	add_entry("mbc1_mode1_rd", 0, 0, 0, OP_RDIMG, 'h4000, 0, 'h7C000);
	// ram window, MBC1 in mode 1 with ram bank 1
	add_entry("ram_closed_rd", 0, 0, 0, OP_RD, 'hA010, 0, 'hFF);
	add_entry("ram_open", 0, 0, 0, OP_WR, 'h0000, 'h0A, 0);
	add_entry("ram_b1_wr", 0, 0, 0, OP_WR, 'hA010, 'h5A, 0);
	add_entry("ram_b1_wr_hi", 0, 0, 0, OP_WR, 'hA011, 'h77, 0);
	add_entry("ram_sel_b2", 0, 0, 0, OP_WR, 'h4000, 'h02, 0);
	add_entry("ram_b2_wr", 0, 0, 0, OP_WR, 'hA010, 'hC3, 0);
	add_entry("ram_b2_rd", 0, 0, 0, OP_RD, 'hA010, 0, 'hC3);
	add_entry("ram_sel_b1", 0, 0, 0, OP_WR, 'h4000, 'h01, 0);
	add_entry("ram_b1_rd", 0, 0, 0, OP_RD, 'hA010, 0, 'h5A);
	add_entry("ram_b1_rd_hi", 0, 0, 0, OP_RD, 'hA011, 0, 'h77);
	add_entry("ram_close", 0, 0, 0, OP_WR, 'h0000, 'h00, 0);
	add_entry("ram_closed_rd2", 0, 0, 0, OP_RD, 'hA010, 0, 'hFF);
	add_entry("ram_lost_wr", 0, 0, 0, OP_WR, 'hA010, 'h99, 0);   // dropped
	add_entry("ram_reopen", 0, 0, 0, OP_WR, 'h0000, 'h0A, 0);
	add_entry("ram_kept_rd", 0, 0, 0, OP_RD, 'hA010, 0, 'h5A);
	// MBC2, nibble ram
	add_entry("mbc2_dl", 'h05, 'h02, 'h00, OP_DL, 0, 0, 0);
	add_entry("mbc2_open", 0, 0, 0, OP_WR, 'h0000, 'h0A, 0);
	add_entry("mbc2_wr", 0, 0, 0, OP_WR, 'hA005, 'hB6, 0);
	add_entry("mbc2_rd", 0, 0, 0, OP_RD, 'hA005, 0, 'hF6);
	add_entry("mbc2_bank3", 0, 0, 0, OP_WR, 'h2000, 'h03, 0);
	add_entry("mbc2_bank3_rd", 0, 0, 0, OP_RDIMG, 'h4000, 0, 'h0C000);
	// MBC5, bank 0 legal at 4000, mask 0x0F
	add_entry("mbc5_dl", 'h19, 'h03, 'h03, OP_DL, 0, 0, 0);
	add_entry("mbc5_bank0", 0, 0, 0, OP_WR, 'h2000, 'h00, 0);
	add_entry("mbc5_bank0_rd", 0, 0, 0, OP_RDIMG, 'h6000, 0, 'h02000);
	add_entry("mbc5_mirror", 0, 0, 0, OP_WR, 'h2000, 'h13, 0);
	add_entry("mbc5_mirror_rd", 0, 0, 0, OP_RDIMG, 'h4000, 0, 'h0C000);
	// MBC3, clock select unmaps the ram
	add_entry("mbc3_dl", 'h13, 'h04, 'h03, OP_DL, 0, 0, 0);
	add_entry("mbc3_open", 0, 0, 0, OP_WR, 'h0000, 'h0A, 0);
	add_entry("mbc3_sel_b2", 0, 0, 0, OP_WR, 'h4000, 'h02, 0);
	add_entry("mbc3_b2_wr", 0, 0, 0, OP_WR, 'hA040, 'h81, 0);
	add_entry("mbc3_clk_sel", 0, 0, 0, OP_WR, 'h4000, 'h08, 0);
	add_entry("mbc3_clk_rd", 0, 0, 0, OP_RDIMG, 'hA000, 0, 'h00000);   // word 0 of rom
	add_entry("mbc3_ram_back", 0, 0, 0, OP_WR, 'h4000, 'h02, 0);
	add_entry("mbc3_b2_rd", 0, 0, 0, OP_RD, 'hA040, 0, 'h81);
	add_entry("mbc3_bank10", 0, 0, 0, OP_WR, 'h2000, 'h0A, 0);
	add_entry("mbc3_bank10_rd", 0, 0, 0, OP_RDIMG, 'h4000, 0, 'h28000);
	// a new download puts the mapper back to power-on state
	add_entry("mbc3_redl", 'h13, 'h04, 'h03, OP_DL, 0, 0, 0);
	add_entry("mbc3_redl_rd", 0, 0, 0, OP_RDIMG, 'h4000, 0, 'h04000);
	add_entry("mbc3_redl_ram", 0, 0, 0, OP_RD, 'hA040, 0, 'hFF);
endtask

/* test/cart_tb.sv */
// Testbench for the cartridge top level. Downloads images through the host
// port, then runs the step table against the CPU bus and checks each read.

`timescale 1ns/1ps
`default_nettype none

module cart_tb;
	import cart_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int HALF_BYTES = 'h2000;                      // one 8k rom half
	localparam int WIN_BYTES  = 64;                          // sent from the start of each half
	localparam int HALVES     = 256;                         // 2M image space
	localparam int DL_WORDS   = HALVES * WIN_BYTES / 2 + 2;  // plus the two header words

	logic                   clk_sys;
	logic                   reset;
	logic                   dl_active;
	logic                   dl_wr;
	logic [DL_ADDR_W-1:0]   dl_addr;
	logic [MEM_DATA_W-1:0]  dl_data;
	wire                    dl_wait;
	logic [CART_ADDR_W-1:0] cart_addr;
	logic                   cart_rd;
	logic                   cart_wr;
	logic [CART_DATA_W-1:0] cart_di;
	wire  [CART_DATA_W-1:0] cart_do;

	int              errors;
	int              checks;
	int              seed;
	logic [8*16-1:0] cur_name;   // name of the running step, for error lines

	`include "cart_tb_table.svh"

	cart_top cart_top_i (
		.clk_sys, .reset, .dl_active, .dl_wr, .dl_addr, .dl_data, .dl_wait,
		.cart_addr, .cart_rd, .cart_wr, .cart_di, .cart_do
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD/2) clk_sys = ~clk_sys;
	end

	// image content, bits above 15 keep the rom banks apart
	function automatic logic [7:0] image_byte(input logic [DL_ADDR_W-1:0] a);
		return a[7:0] * 8'd7 + a[15:8] + a[23:16];
	endfunction

	// ------------------------------------------------------------
	// host download, one word per wait window
	// ------------------------------------------------------------
	task automatic send_word(input logic [DL_ADDR_W-1:0] a, input logic [15:0] d);
		int n;
		n       = 0;
		dl_addr = a;
		dl_data = d;
		dl_wr   = 1'b1;
		@(posedge clk_sys);
		#1;
		dl_wr = 1'b0;
		if (!dl_wait) begin
			errors++;
			$display("[ERROR] %0s: dl_wait did not rise after dl_wr at %h", cur_name, a);
		end
		while (dl_wait && n < 8) begin   // bounded, a stuck wait is an error
			@(posedge clk_sys);
			#1;
			n++;
		end
		checks++;
		if (n != 2) begin
			errors++;
			$display("[ERROR] %0s: wait cycles at %h expected 2 actual %0d", cur_name, a, n);
		end
	endtask

	task automatic download_image(input logic [7:0] mtype, input logic [7:0] rom,
			input logic [7:0] ram);
		logic [DL_ADDR_W-1:0] a;
		int                   h;
		int                   w;
		dl_active = 1'b1;
		@(posedge clk_sys);
		#1;
		for (h = 0; h < HALVES; h++) begin
			for (w = 0; w < WIN_BYTES; w += 2) begin
				a = h * HALF_BYTES + w;
				send_word(a, {image_byte(a + 1), image_byte(a)});   // even byte low
			end
		end
		send_word(HDR_TYPE_ADDR, {mtype, image_byte(HDR_TYPE_ADDR)});
		send_word(HDR_SIZE_ADDR, {ram, rom});
		dl_active = 1'b0;
	endtask

	// ------------------------------------------------------------
	// cpu bus, one cycle per access
	// ------------------------------------------------------------
	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		cart_addr = addr;
		cart_di   = data;
		cart_wr   = 1'b1;
		@(posedge clk_sys);
		#1;
		cart_wr = 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
		cart_addr = addr;
		cart_rd   = 1'b1;
		@(posedge clk_sys);
		#1;
		cart_rd = 1'b0;
		data    = cart_do;   // valid the cycle after the strobe
	endtask

	initial begin
		int         i;
		int         off;
		logic [7:0] got;
		logic [7:0] exp_byte;
		errors    = 0;
		checks    = 0;
		seed      = 70345;
		cur_name  = "reset";
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		cart_addr = '0;
		cart_rd   = 1'b0;
		cart_wr   = 1'b0;
		cart_di   = '0;
		load_table();
		repeat (3) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		for (i = 0; i < n_entries; i++) begin
			cur_name = t_name[i];
			if (t_op[i] == OP_DL) begin
				download_image(t_type[i], t_rom[i], t_ram[i]);
			end else if (t_op[i] == OP_WR) begin
				cpu_write(t_addr[i], t_data[i]);
			end else begin
				off = (t_op[i] == OP_RDIMG) ? ($random(seed) & 'h3F) : 0;   // stays in window
				cpu_read(t_addr[i] + off, got);
				exp_byte = (t_op[i] == OP_RDIMG) ? image_byte(t_exp[i] + off) : t_exp[i][7:0];
				checks++;
				if (got !== exp_byte) begin
					errors++;
					$display("[ERROR] %0s: addr %h expected %h actual %h",
						cur_name, t_addr[i] + off, exp_byte, got);
				end
			end
		end

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// watchdog, every step budgeted as a full download
	initial begin
		longint limit_ns;
		wait (n_entries > 0);
		limit_ns = longint'(n_entries) * (DL_WORDS * 4 + 32) * CLK_PERIOD;
		#(limit_ns);
		$display("timeout: the table did not finish within %0d ns", limit_ns);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
